// ==== include/softmax_defines.svh ====
`ifndef SOFTMAX_DEFINES_SVH
`define SOFTMAX_DEFINES_SVH

`define VEC_LEN 8
`define X_W     8
`define E_W     12
`define SUM_W   16
`define ADDR_W  8

`endif

// ==== hdl/fixed_point_pkg.sv ====
`default_nettype none

`include "softmax_defines.svh"

package fixed_point_pkg;
    typedef logic signed [`X_W-1:0]        q4_4_t;     // score, 4 integer and 4 fraction bits.
    typedef logic [`E_W-1:0]               exp_t;      // 0x100 is 1.0.
    typedef logic [`SUM_W-1:0]             sum_t;
    typedef logic [$clog2(`VEC_LEN)-1:0]   vec_idx_t;
endpackage

`default_nettype wire

// ==== hdl/exp_regs_pkg.sv ====
`default_nettype none

`include "softmax_defines.svh"

package exp_regs_pkg;
    localparam logic [`ADDR_W-1:0] CTRL_OFS   = 'h00;
    localparam logic [`ADDR_W-1:0] STATUS_OFS = 'h04;
    localparam logic [`ADDR_W-1:0] SUM_OFS    = 'h08;
    localparam logic [`ADDR_W-1:0] X_BASE     = 'h40;  // one score per word.
    localparam logic [`ADDR_W-1:0] E_BASE     = 'h80;
    localparam int BUSY_BIT = 0;
    localparam int DONE_BIT = 1;
endpackage

`default_nettype wire

// ==== hdl/exp_lut.sv ====
`timescale 1ns/1ps
`default_nettype none

module exp_lut #(
    parameter DATA_IN_0_PRECISION_0  = 8,
    parameter DATA_IN_0_PRECISION_1  = 4,
    parameter DATA_OUT_0_PRECISION_0 = 12,
    parameter DATA_OUT_0_PRECISION_1 = 8
) (
    input  logic [DATA_IN_0_PRECISION_0-1:0]  data_in_0,
    output logic [DATA_OUT_0_PRECISION_0-1:0] data_out_0
);
    localparam logic [DATA_IN_0_PRECISION_0-1:0] X_ONE = 1 << DATA_IN_0_PRECISION_1;
    localparam logic [DATA_OUT_0_PRECISION_0-1:0] E_ONE = 1 << DATA_OUT_0_PRECISION_1;

    always_comb begin
        case (data_in_0)
            8'h00: data_out_0 = E_ONE;  // e^0.
            8'h01: data_out_0 = 12'h111;
            8'h02: data_out_0 = 12'h122;
            8'h03: data_out_0 = 12'h135;
            8'h04: data_out_0 = 12'h149;
            8'h05: data_out_0 = 12'h15E;
            8'h06: data_out_0 = 12'h174;
            8'h07: data_out_0 = 12'h18D;
            8'h08: data_out_0 = 12'h1A6;
            8'h09: data_out_0 = 12'h1C1;
            8'h0A: data_out_0 = 12'h1DE;
            8'h0B: data_out_0 = 12'h1FD;
            8'h0C: data_out_0 = 12'h21E;
            8'h0D: data_out_0 = 12'h241;
            8'h0E: data_out_0 = 12'h266;
            8'h0F: data_out_0 = 12'h28E;
            X_ONE: data_out_0 = 12'h2B8;  // e^1.
            8'h11: data_out_0 = 12'h2E5;
            8'h12: data_out_0 = 12'h315;
            8'h13: data_out_0 = 12'h347;
            8'h14: data_out_0 = 12'h37E;
            8'h15: data_out_0 = 12'h3B7;
            8'h16: data_out_0 = 12'h3F4;
            8'h17: data_out_0 = 12'h436;
            8'h18: data_out_0 = 12'h47B;
            8'h19: data_out_0 = 12'h4C5;
            8'h1A: data_out_0 = 12'h514;
            8'h1B: data_out_0 = 12'h568;
            8'h1C: data_out_0 = 12'h5C1;
            8'h1D: data_out_0 = 12'h620;
            8'h1E: data_out_0 = 12'h685;
            8'h1F: data_out_0 = 12'h6F1;
            8'h20: data_out_0 = 12'h764;
            8'h21: data_out_0 = 12'h7DE;
            8'h22: data_out_0 = 12'h7FF;  // saturates from here to 0x7F.
            8'h23: data_out_0 = 12'h7FF;
            8'h24: data_out_0 = 12'h7FF;
            8'h25: data_out_0 = 12'h7FF;
            8'h26: data_out_0 = 12'h7FF;
            8'h27: data_out_0 = 12'h7FF;
            8'h28: data_out_0 = 12'h7FF;
            8'h29: data_out_0 = 12'h7FF;
            8'h2A: data_out_0 = 12'h7FF;
            8'h2B: data_out_0 = 12'h7FF;
            8'h2C: data_out_0 = 12'h7FF;
            8'h2D: data_out_0 = 12'h7FF;
            8'h2E: data_out_0 = 12'h7FF;
            8'h2F: data_out_0 = 12'h7FF;
            8'h30: data_out_0 = 12'h7FF;
            8'h31: data_out_0 = 12'h7FF;
            8'h32: data_out_0 = 12'h7FF;
            8'h33: data_out_0 = 12'h7FF;
            8'h34: data_out_0 = 12'h7FF;
            8'h35: data_out_0 = 12'h7FF;
            8'h36: data_out_0 = 12'h7FF;
            8'h37: data_out_0 = 12'h7FF;
            8'h38: data_out_0 = 12'h7FF;
            8'h39: data_out_0 = 12'h7FF;
            8'h3A: data_out_0 = 12'h7FF;
            8'h3B: data_out_0 = 12'h7FF;
            8'h3C: data_out_0 = 12'h7FF;
            8'h3D: data_out_0 = 12'h7FF;
            8'h3E: data_out_0 = 12'h7FF;
            8'h3F: data_out_0 = 12'h7FF;
            8'h40: data_out_0 = 12'h7FF;
            8'h41: data_out_0 = 12'h7FF;
            8'h42: data_out_0 = 12'h7FF;
            8'h43: data_out_0 = 12'h7FF;
            8'h44: data_out_0 = 12'h7FF;
            8'h45: data_out_0 = 12'h7FF;
            8'h46: data_out_0 = 12'h7FF;
            8'h47: data_out_0 = 12'h7FF;
            8'h48: data_out_0 = 12'h7FF;
            8'h49: data_out_0 = 12'h7FF;
            8'h4A: data_out_0 = 12'h7FF;
            8'h4B: data_out_0 = 12'h7FF;
            8'h4C: data_out_0 = 12'h7FF;
            8'h4D: data_out_0 = 12'h7FF;
            8'h4E: data_out_0 = 12'h7FF;
            8'h4F: data_out_0 = 12'h7FF;
            8'h50: data_out_0 = 12'h7FF;
            8'h51: data_out_0 = 12'h7FF;
            8'h52: data_out_0 = 12'h7FF;
            8'h53: data_out_0 = 12'h7FF;
            8'h54: data_out_0 = 12'h7FF;
            8'h55: data_out_0 = 12'h7FF;
            8'h56: data_out_0 = 12'h7FF;
            8'h57: data_out_0 = 12'h7FF;
            8'h58: data_out_0 = 12'h7FF;
            8'h59: data_out_0 = 12'h7FF;
            8'h5A: data_out_0 = 12'h7FF;
            8'h5B: data_out_0 = 12'h7FF;
            8'h5C: data_out_0 = 12'h7FF;
            8'h5D: data_out_0 = 12'h7FF;
            8'h5E: data_out_0 = 12'h7FF;
            8'h5F: data_out_0 = 12'h7FF;
            8'h60: data_out_0 = 12'h7FF;
            8'h61: data_out_0 = 12'h7FF;
            8'h62: data_out_0 = 12'h7FF;
            8'h63: data_out_0 = 12'h7FF;
            8'h64: data_out_0 = 12'h7FF;
            8'h65: data_out_0 = 12'h7FF;
            8'h66: data_out_0 = 12'h7FF;
            8'h67: data_out_0 = 12'h7FF;
            8'h68: data_out_0 = 12'h7FF;
            8'h69: data_out_0 = 12'h7FF;
            8'h6A: data_out_0 = 12'h7FF;
            8'h6B: data_out_0 = 12'h7FF;
            8'h6C: data_out_0 = 12'h7FF;
            8'h6D: data_out_0 = 12'h7FF;
            8'h6E: data_out_0 = 12'h7FF;
            8'h6F: data_out_0 = 12'h7FF;
            8'h70: data_out_0 = 12'h7FF;
            8'h71: data_out_0 = 12'h7FF;
            8'h72: data_out_0 = 12'h7FF;
            8'h73: data_out_0 = 12'h7FF;
            8'h74: data_out_0 = 12'h7FF;
            8'h75: data_out_0 = 12'h7FF;
            8'h76: data_out_0 = 12'h7FF;
            8'h77: data_out_0 = 12'h7FF;
            8'h78: data_out_0 = 12'h7FF;
            8'h79: data_out_0 = 12'h7FF;
            8'h7A: data_out_0 = 12'h7FF;
            8'h7B: data_out_0 = 12'h7FF;
            8'h7C: data_out_0 = 12'h7FF;
            8'h7D: data_out_0 = 12'h7FF;
            8'h7E: data_out_0 = 12'h7FF;
            8'h7F: data_out_0 = 12'h7FF;
            8'h80: data_out_0 = 12'h000;  // below 2^-8, rounds to zero.
            8'h81: data_out_0 = 12'h000;
            8'h82: data_out_0 = 12'h000;
            8'h83: data_out_0 = 12'h000;
            8'h84: data_out_0 = 12'h000;
            8'h85: data_out_0 = 12'h000;
            8'h86: data_out_0 = 12'h000;
            8'h87: data_out_0 = 12'h000;
            8'h88: data_out_0 = 12'h000;
            8'h89: data_out_0 = 12'h000;
            8'h8A: data_out_0 = 12'h000;
            8'h8B: data_out_0 = 12'h000;
            8'h8C: data_out_0 = 12'h000;
            8'h8D: data_out_0 = 12'h000;
            8'h8E: data_out_0 = 12'h000;
            8'h8F: data_out_0 = 12'h000;
            8'h90: data_out_0 = 12'h000;
            8'h91: data_out_0 = 12'h000;
            8'h92: data_out_0 = 12'h000;
            8'h93: data_out_0 = 12'h000;
            8'h94: data_out_0 = 12'h000;
            8'h95: data_out_0 = 12'h000;
            8'h96: data_out_0 = 12'h000;
            8'h97: data_out_0 = 12'h000;
            8'h98: data_out_0 = 12'h000;
            8'h99: data_out_0 = 12'h000;
            8'h9A: data_out_0 = 12'h000;
            8'h9B: data_out_0 = 12'h000;
            8'h9C: data_out_0 = 12'h000;
            8'h9D: data_out_0 = 12'h001;
            8'h9E: data_out_0 = 12'h001;
            8'h9F: data_out_0 = 12'h001;
            8'hA0: data_out_0 = 12'h001;
            8'hA1: data_out_0 = 12'h001;
            8'hA2: data_out_0 = 12'h001;
            8'hA3: data_out_0 = 12'h001;
            8'hA4: data_out_0 = 12'h001;
            8'hA5: data_out_0 = 12'h001;
            8'hA6: data_out_0 = 12'h001;
            8'hA7: data_out_0 = 12'h001;
            8'hA8: data_out_0 = 12'h001;
            8'hA9: data_out_0 = 12'h001;
            8'hAA: data_out_0 = 12'h001;
            8'hAB: data_out_0 = 12'h001;
            8'hAC: data_out_0 = 12'h001;
            8'hAD: data_out_0 = 12'h001;
            8'hAE: data_out_0 = 12'h002;
            8'hAF: data_out_0 = 12'h002;
            8'hB0: data_out_0 = 12'h002;
            8'hB1: data_out_0 = 12'h002;
            8'hB2: data_out_0 = 12'h002;
            8'hB3: data_out_0 = 12'h002;
            8'hB4: data_out_0 = 12'h002;
            8'hB5: data_out_0 = 12'h002;
            8'hB6: data_out_0 = 12'h003;
            8'hB7: data_out_0 = 12'h003;
            8'hB8: data_out_0 = 12'h003;
            8'hB9: data_out_0 = 12'h003;
            8'hBA: data_out_0 = 12'h003;
            8'hBB: data_out_0 = 12'h003;
            8'hBC: data_out_0 = 12'h004;
            8'hBD: data_out_0 = 12'h004;
            8'hBE: data_out_0 = 12'h004;
            8'hBF: data_out_0 = 12'h004;
            8'hC0: data_out_0 = 12'h005;
            8'hC1: data_out_0 = 12'h005;
            8'hC2: data_out_0 = 12'h005;
            8'hC3: data_out_0 = 12'h006;
            8'hC4: data_out_0 = 12'h006;
            8'hC5: data_out_0 = 12'h006;
            8'hC6: data_out_0 = 12'h007;
            8'hC7: data_out_0 = 12'h007;
            8'hC8: data_out_0 = 12'h008;
            8'hC9: data_out_0 = 12'h008;
            8'hCA: data_out_0 = 12'h009;
            8'hCB: data_out_0 = 12'h009;
            8'hCC: data_out_0 = 12'h00A;
            8'hCD: data_out_0 = 12'h00B;
            8'hCE: data_out_0 = 12'h00B;
            8'hCF: data_out_0 = 12'h00C;
            8'hD0: data_out_0 = 12'h00D;
            8'hD1: data_out_0 = 12'h00E;
            8'hD2: data_out_0 = 12'h00E;
            8'hD3: data_out_0 = 12'h00F;
            8'hD4: data_out_0 = 12'h010;
            8'hD5: data_out_0 = 12'h011;
            8'hD6: data_out_0 = 12'h013;
            8'hD7: data_out_0 = 12'h014;
            8'hD8: data_out_0 = 12'h015;
            8'hD9: data_out_0 = 12'h016;
            8'hDA: data_out_0 = 12'h018;
            8'hDB: data_out_0 = 12'h019;
            8'hDC: data_out_0 = 12'h01B;
            8'hDD: data_out_0 = 12'h01D;
            8'hDE: data_out_0 = 12'h01F;
            8'hDF: data_out_0 = 12'h021;
            8'hE0: data_out_0 = 12'h023;
            8'hE1: data_out_0 = 12'h025;
            8'hE2: data_out_0 = 12'h027;
            8'hE3: data_out_0 = 12'h02A;
            8'hE4: data_out_0 = 12'h02C;
            8'hE5: data_out_0 = 12'h02F;
            8'hE6: data_out_0 = 12'h032;
            8'hE7: data_out_0 = 12'h036;
            8'hE8: data_out_0 = 12'h039;
            8'hE9: data_out_0 = 12'h03D;
            8'hEA: data_out_0 = 12'h041;
            8'hEB: data_out_0 = 12'h045;
            8'hEC: data_out_0 = 12'h049;
            8'hED: data_out_0 = 12'h04E;
            8'hEE: data_out_0 = 12'h053;
            8'hEF: data_out_0 = 12'h058;
            8'hF0: data_out_0 = 12'h05E;
            8'hF1: data_out_0 = 12'h064;
            8'hF2: data_out_0 = 12'h06B;
            8'hF3: data_out_0 = 12'h072;
            8'hF4: data_out_0 = 12'h079;
            8'hF5: data_out_0 = 12'h081;
            8'hF6: data_out_0 = 12'h089;
            8'hF7: data_out_0 = 12'h092;
            8'hF8: data_out_0 = 12'h09B;
            8'hF9: data_out_0 = 12'h0A5;
            8'hFA: data_out_0 = 12'h0B0;
            8'hFB: data_out_0 = 12'h0BB;
            8'hFC: data_out_0 = 12'h0C7;
            8'hFD: data_out_0 = 12'h0D4;
            8'hFE: data_out_0 = 12'h0E2;
            8'hFF: data_out_0 = 12'h0F0;
            default: data_out_0 = '0;
        endcase
    end
endmodule

`default_nettype wire

// ==== hdl/shared_vec_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module shared_vec_mem
    import fixed_point_pkg::*;
#(
    parameter type word_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     a_req,
    input  logic     a_we,
    input  vec_idx_t a_addr,
    input  word_t    a_wdata,
    output logic     a_gnt,
    input  logic     b_req,
    input  logic     b_we,
    input  vec_idx_t b_addr,
    input  word_t    b_wdata,
    output logic     b_gnt,
    output word_t    rdata
);
    word_t    mem [`VEC_LEN];
    logic     sel_we;
    vec_idx_t sel_addr;
    word_t    sel_wdata;

    assign b_gnt     = b_req;
    assign a_gnt     = a_req && !b_req;  // port a stalls while port b is active.
    assign sel_we    = b_req ? b_we : a_we;
    assign sel_addr  = b_req ? b_addr : a_addr;
    assign sel_wdata = b_req ? b_wdata : a_wdata;

    always_ff @(posedge clk) begin
        if (rst_n && (a_gnt || b_gnt)) begin
            if (sel_we) begin
                mem[sel_addr] <= sel_wdata;
            end else begin
                rdata <= mem[sel_addr];  // valid the cycle after the grant.
            end
        end
    end
endmodule

`default_nettype wire

// ==== hdl/exp_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module exp_engine
    import fixed_point_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    output logic     busy,
    output logic     done,
    output sum_t     sum,
    output logic     x_req,
    output vec_idx_t x_addr,
    input  q4_4_t    x_rdata,
    output logic     e_req,
    output logic     e_we,
    output vec_idx_t e_addr,
    output exp_t     e_wdata
);
    logic     rd_active;
    vec_idx_t rd_cnt;
    logic     wr_valid;
    vec_idx_t wr_idx;
    logic     accept;

    assign accept = start && !busy;  // restart only once idle.
    assign busy   = rd_active || wr_valid;
    assign x_req  = rd_active;
    assign x_addr = rd_cnt;
    assign e_req  = wr_valid;
    assign e_we   = wr_valid;
    assign e_addr = wr_idx;

    exp_lut u_exp_lut (
        .data_in_0  (x_rdata),
        .data_out_0 (e_wdata)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_active <= 1'b0;
            rd_cnt    <= '0;
            wr_valid  <= 1'b0;
            wr_idx    <= '0;
            done      <= 1'b0;
            sum       <= '0;
        end else begin
            wr_valid <= rd_active;  // score arrives one cycle after its read.
            wr_idx   <= rd_cnt;
            if (accept) begin
                rd_active <= 1'b1;
                rd_cnt    <= '0;
                done      <= 1'b0;
                sum       <= '0;
            end else begin
                if (rd_active) begin
                    rd_cnt <= rd_cnt + 1'b1;
                    if (rd_cnt == vec_idx_t'(`VEC_LEN - 1)) begin
                        rd_active <= 1'b0;
                    end
                end
                if (wr_valid) begin
                    sum <= sum + sum_t'(e_wdata);
                end
                if (wr_valid && !rd_active) begin
                    done <= 1'b1;  // last write retires.
                end
            end
        end
    end
endmodule

`default_nettype wire

// ==== hdl/apb_exp_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module apb_exp_regs
    import fixed_point_pkg::*;
    import exp_regs_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`ADDR_W-1:0] paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               start,
    input  logic               busy,
    input  logic               done,
    input  sum_t               sum,
    output logic               xa_req,
    output logic               xa_we,
    output vec_idx_t           xa_addr,
    output q4_4_t              xa_wdata,
    input  logic               xa_gnt,
    input  q4_4_t              x_rdata,
    output logic               ea_req,
    output vec_idx_t           ea_addr,
    input  logic               ea_gnt,
    input  exp_t               e_rdata
);
    typedef enum logic [1:0] {IDLE, WAIT_GNT, RDATA} state_t;

    localparam logic [`ADDR_W-1:0] WIN_SPAN = `ADDR_W'(4 * `VEC_LEN);

    state_t state;
    logic   access;
    logic   is_ctrl;
    logic   is_status;
    logic   is_sum;
    logic   is_x;
    logic   is_e;
    logic   err;
    logic   win;

    assign access    = psel && penable;
    assign is_ctrl   = paddr == CTRL_OFS;
    assign is_status = paddr == STATUS_OFS;
    assign is_sum    = paddr == SUM_OFS;
    assign is_x = paddr >= X_BASE && paddr < X_BASE + WIN_SPAN && paddr[1:0] == 2'b00;
    assign is_e = paddr >= E_BASE && paddr < E_BASE + WIN_SPAN && paddr[1:0] == 2'b00;
    assign err  = !(is_ctrl || is_status || is_sum || is_x || is_e)
                  || (pwrite && (is_status || is_sum || is_e));  // read-only targets.
    assign win  = (is_x || is_e) && !err;

    assign xa_req   = access && win && is_x && state != RDATA;
    assign xa_we    = pwrite;
    assign xa_addr  = vec_idx_t'(paddr >> 2);
    assign xa_wdata = pwdata[`X_W-1:0];
    assign ea_req   = access && win && is_e && state != RDATA;
    assign ea_addr  = vec_idx_t'(paddr >> 2);

    assign pready  = state == RDATA || (state == IDLE && access && !win);
    assign pslverr = state == IDLE && access && err;
    assign start   = state == IDLE && access && pwrite && is_ctrl && pwdata[0];

    always_comb begin
        prdata = '0;
        if (state == RDATA) begin
            prdata = is_x ? 32'($unsigned(x_rdata)) : 32'(e_rdata);
        end else if (is_status) begin
            prdata[BUSY_BIT] = busy;
            prdata[DONE_BIT] = done;
        end else if (is_sum) begin
            prdata = 32'(sum);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (access && win) begin
                        state <= (xa_gnt || ea_gnt) ? RDATA : WAIT_GNT;
                    end
                end
                WAIT_GNT: begin
                    if (xa_gnt || ea_gnt) begin
                        state <= RDATA;  // engine released the memory.
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end
endmodule

`default_nettype wire

// ==== hdl/softmax_exp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module softmax_exp_top
    import fixed_point_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`ADDR_W-1:0] paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               exp_done
);
    logic     start;
    logic     busy;
    logic     done;
    sum_t     sum;
    logic     xa_req;
    logic     xa_we;
    vec_idx_t xa_addr;
    q4_4_t    xa_wdata;
    logic     xa_gnt;
    q4_4_t    x_rdata;
    logic     ea_req;
    vec_idx_t ea_addr;
    logic     ea_gnt;
    exp_t     e_rdata;
    logic     x_req;
    vec_idx_t x_addr;
    logic     e_req;
    logic     e_we;
    vec_idx_t e_addr;
    exp_t     e_wdata;

    assign exp_done = done;

    apb_exp_regs u_regs (.*);

    exp_engine u_engine (.*);

    shared_vec_mem #(.word_t(q4_4_t)) x_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .a_req   (xa_req),
        .a_we    (xa_we),
        .a_addr  (xa_addr),
        .a_wdata (xa_wdata),
        .a_gnt   (xa_gnt),
        .b_req   (x_req),
        .b_we    (1'b0),  // engine only reads scores.
        .b_addr  (x_addr),
        .b_wdata ('0),
        .b_gnt   (),
        .rdata   (x_rdata)
    );

    shared_vec_mem #(.word_t(exp_t)) e_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .a_req   (ea_req),
        .a_we    (1'b0),  // exponent window is read-only.
        .a_addr  (ea_addr),
        .a_wdata ('0),
        .a_gnt   (ea_gnt),
        .b_req   (e_req),
        .b_we    (e_we),
        .b_addr  (e_addr),
        .b_wdata (e_wdata),
        .b_gnt   (),
        .rdata   (e_rdata)
    );
endmodule

`default_nettype wire

// ==== tb/tb_softmax_exp.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module tb_softmax_exp
    import fixed_point_pkg::*;
    import exp_regs_pkg::*;
();
    localparam int CLK_PERIOD      = 20;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;

    logic               clk;
    logic               rst_n;
    logic [`ADDR_W-1:0] paddr;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [31:0]        pwdata;
    logic [31:0]        prdata;
    logic               pready;
    logic               pslverr;
    logic               exp_done;
    logic [7:0]         cur_score [`VEC_LEN];

    logic [7:0]  ref_score [`VEC_LEN] = '{8'h00, 8'h01, 8'h10, 8'hFF,
                                          8'hF0, 8'h22, 8'h7F, 8'h80};
    logic [11:0] ref_exp [`VEC_LEN]   = '{12'h100, 12'h111, 12'h2B8, 12'h0F0,
                                          12'h05E, 12'h7FF, 12'h7FF, 12'h000};

    softmax_exp_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * (NUM_TESTS * CYCLES_PER_TEST + 2));
        $display("Timeout: the tests did not finish in time");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [`ADDR_W-1:0] x_word_addr(input int idx);
        return X_BASE + `ADDR_W'(4 * idx);
    endfunction

    function automatic logic [`ADDR_W-1:0] e_word_addr(input int idx);
        return E_BASE + `ADDR_W'(4 * idx);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("Error: %s = 0x%0h, expected 0x%0h", name, got, expected);
            $display("Checks failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Error: %s", what);
            $display("Checks failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic apb_access(input logic [`ADDR_W-1:0] addr, input logic write,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) @(negedge clk);  // window accesses stall until granted.
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [`ADDR_W-1:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused;
        apb_access(addr, 1'b1, data, unused, err);
    endtask

    task automatic apb_read(input logic [`ADDR_W-1:0] addr, output logic [31:0] data,
                            output logic err);
        apb_access(addr, 1'b0, 32'h0, data, err);
    endtask

    task automatic write_scores();
        logic err;
        for (int i = 0; i < `VEC_LEN; i++) begin
            apb_write(x_word_addr(i), {24'h0, cur_score[i]}, err);
            check_value("pslverr", 32'(err), 32'h0);
        end
    endtask

    task automatic wait_engine_done(output logic [31:0] status);
        logic err;
        status = '0;
        while (!status[DONE_BIT]) begin
            apb_read(STATUS_OFS, status, err);
            check_value("pslverr", 32'(err), 32'h0);
        end
    endtask

    task automatic check_reset_state();
        logic [31:0] data;
        logic        err;
        apb_read(STATUS_OFS, data, err);
        check_value("STATUS", data, 32'h0);
        check_value("pslverr", 32'(err), 32'h0);
        @(negedge clk);
        check_value("exp_done", 32'(exp_done), 32'h0);
        apb_read(SUM_OFS, data, err);
        check_value("SUM", data, 32'h0);
    endtask

    task automatic score_readback();
        logic [31:0] data;
        logic        err;
        cur_score = ref_score;
        write_scores();
        for (int i = 0; i < `VEC_LEN; i++) begin
            apb_read(x_word_addr(i), data, err);
            check_value($sformatf("X[%0d]", i), data, {24'h0, ref_score[i]});
            check_value("pslverr", 32'(err), 32'h0);
        end
    endtask

    task automatic run_reference_vector();
        logic [31:0] data;
        logic [31:0] status;
        logic [31:0] expected_sum;
        logic        err;
        apb_write(CTRL_OFS, 32'h1, err);
        wait_engine_done(status);
        check_value("STATUS.BUSY", 32'(status[BUSY_BIT]), 32'h0);
        @(negedge clk);
        check_value("exp_done", 32'(exp_done), 32'h1);
        expected_sum = '0;
        for (int i = 0; i < `VEC_LEN; i++) begin
            apb_read(e_word_addr(i), data, err);
            check_value($sformatf("E[%0d]", i), data, 32'(ref_exp[i]));
            expected_sum += 32'(ref_exp[i]);
        end
        apb_read(SUM_OFS, data, err);
        check_value("SUM", data, expected_sum);
    endtask

    task automatic run_sorted_random();
        logic [31:0] data;
        logic [31:0] status;
        logic [31:0] prev;
        logic [31:0] read_sum;
        logic [7:0]  tmp;
        logic        err;
        for (int i = 0; i < `VEC_LEN; i++) begin
            cur_score[i] = 8'($urandom % 34);  // 0x00 to 0x21 stays below saturation.
        end
        for (int i = 1; i < `VEC_LEN; i++) begin
            for (int j = i; j > 0 && cur_score[j-1] > cur_score[j]; j--) begin
                tmp            = cur_score[j];
                cur_score[j]   = cur_score[j-1];
                cur_score[j-1] = tmp;
            end
        end
        write_scores();
        apb_write(CTRL_OFS, 32'h1, err);
        wait_engine_done(status);
        prev     = '0;
        read_sum = '0;
        for (int i = 0; i < `VEC_LEN; i++) begin
            apb_read(e_word_addr(i), data, err);
            check_true(data >= 32'h100,
                       $sformatf("E[%0d] = 0x%0h, expected at least 0x100", i, data));
            check_true(data >= prev,
                       $sformatf("E[%0d] = 0x%0h, expected at least 0x%0h", i, data, prev));
            prev      = data;
            read_sum += data;
        end
        apb_read(SUM_OFS, data, err);
        check_value("SUM", data, read_sum);
    endtask

    task automatic access_during_busy();
        logic [31:0] data;
        logic [31:0] status;
        logic [31:0] expected_sum;
        logic        err;
        cur_score = ref_score;
        write_scores();
        apb_write(CTRL_OFS, 32'h1, err);
        apb_write(CTRL_OFS, 32'h1, err);  // lands while busy.
        apb_read(x_word_addr(5), data, err);  // held off by the engine's reads.
        check_value("X[5]", data, {24'h0, ref_score[5]});
        check_value("pslverr", 32'(err), 32'h0);
        wait_engine_done(status);
        expected_sum = '0;
        for (int i = 0; i < `VEC_LEN; i++) begin
            expected_sum += 32'(ref_exp[i]);
        end
        apb_read(SUM_OFS, data, err);
        check_value("SUM", data, expected_sum);
    endtask

    task automatic bad_access_errors();
        logic [31:0] sum_before;
        logic [31:0] status_before;
        logic [31:0] e_before;
        logic [31:0] data;
        logic        err;
        apb_read(SUM_OFS, sum_before, err);
        apb_read(STATUS_OFS, status_before, err);
        apb_read(e_word_addr(0), e_before, err);
        apb_write(SUM_OFS, 32'hFFFF, err);
        check_value("pslverr on SUM write", 32'(err), 32'h1);
        apb_write(e_word_addr(0), 32'h0ABC, err);
        check_value("pslverr on E write", 32'(err), 32'h1);
        apb_read(8'h20, data, err);
        check_value("pslverr on 0x20 read", 32'(err), 32'h1);
        apb_write(8'h20, 32'h1, err);
        check_value("pslverr on 0x20 write", 32'(err), 32'h1);
        apb_read(SUM_OFS, data, err);
        check_value("SUM", data, sum_before);
        apb_read(STATUS_OFS, data, err);
        check_value("STATUS", data, status_before);
        apb_read(e_word_addr(0), data, err);
        check_value("E[0]", data, e_before);
    endtask

    initial begin
        void'($urandom(32'h6e11_2e13));
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        check_reset_state();
        score_readback();
        run_reference_vector();
        run_sorted_random();
        access_during_busy();
        bad_access_errors();
        $display("All checks passed");
        $finish;
    end
endmodule

`default_nettype wire

// ==== softmax_exp.f ====
+incdir+include
hdl/fixed_point_pkg.sv
hdl/exp_regs_pkg.sv
hdl/exp_lut.sv
hdl/shared_vec_mem.sv
hdl/exp_engine.sv
hdl/apb_exp_regs.sv
hdl/softmax_exp_top.sv
tb/tb_softmax_exp.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f softmax_exp.f \
		--top-module tb_softmax_exp -o sim_softmax_exp

run: compile
	./obj_dir/sim_softmax_exp > run.log 2>&1; cat run.log
	grep -q "All checks passed" run.log

clean:
	rm -rf obj_dir run.log
